// File: common/dcupIsaPkg.sv
package dcupIsaPkg;

  localparam int WordW     = 16;
  localparam int InstAddrW = 8;
  localparam int DataAddrW = 8;
  localparam int NumRegs   = 8;
  localparam int RegIdxW   = $clog2(NumRegs);
  localparam int OpcodeW   = 5;
  localparam int ValW      = 4;   // Width of val2 and val3

  // Instruction layout {opc[5], r1[3], x, r2[3] | val2[4], x, r3[3] | val3[4]}
  localparam int OpcLsb  = 11;
  localparam int R1Lsb   = 8;
  localparam int R2Lsb   = 4;
  localparam int R3Lsb   = 0;
  localparam int Val2Lsb = 4;
  localparam int Val3Lsb = 0;

  typedef logic [WordW-1:0]     wordT;
  typedef logic [InstAddrW-1:0] instAddrT;
  typedef logic [DataAddrW-1:0] dataAddrT;
  typedef logic [RegIdxW-1:0]   regIdxT;

  typedef enum logic [OpcodeW-1:0] {
    NOP  = 5'b00000, HALT = 5'b00001, LOAD = 5'b00010, STORE = 5'b00011,
    LDIL = 5'b00100, LDIH = 5'b00101, JUMP = 5'b00110, JMPR  = 5'b00111,
    BZ   = 5'b01000, BNZ  = 5'b01001, BN   = 5'b01010, BNN   = 5'b01011,
    BC   = 5'b01100, BNC  = 5'b01101, BB   = 5'b01110, BS    = 5'b01111,
    ADD  = 5'b10000, ADDI = 5'b10001, ADDC = 5'b10010, SUB   = 5'b10011,
    SUBI = 5'b10100, SUBB = 5'b10101, INC  = 5'b10110, CMP   = 5'b10111,
    BE   = 5'b11000, XOR  = 5'b11001, AND  = 5'b11010, OR    = 5'b11011,
    SLL  = 5'b11100, SLA  = 5'b11101, SRL  = 5'b11110, SRA   = 5'b11111
  } opcodeE;

  // Field extraction
  function automatic opcodeE opcodeOf(wordT instr);
    return opcodeE'(instr[OpcLsb +: OpcodeW]);
  endfunction

  function automatic regIdxT r1Of(wordT instr);
    return instr[R1Lsb +: RegIdxW];
  endfunction

  function automatic regIdxT r2Of(wordT instr);
    return instr[R2Lsb +: RegIdxW];
  endfunction

  function automatic regIdxT r3Of(wordT instr);
    return instr[R3Lsb +: RegIdxW];
  endfunction

  function automatic logic [ValW-1:0] val3Of(wordT instr);
    return instr[Val3Lsb +: ValW];
  endfunction

  function automatic logic [2*ValW-1:0] imm8Of(wordT instr);
    return {instr[Val2Lsb +: ValW], instr[Val3Lsb +: ValW]};
  endfunction

endpackage

// File: common/dcupPipePkg.sv
package dcupPipePkg;

  localparam int AluOpW    = 4;
  localparam int ShiftAmtW = 4;   // Shift distance taken from the low bits of B

  // Kept ALU operations
  typedef enum logic [AluOpW-1:0] {
    AluPassB = 4'd0,
    AluAdd   = 4'd1,
    AluSub   = 4'd2,
    AluCmp   = 4'd3,   // Subtract that only sets the flag
    AluAnd   = 4'd4,
    AluOr    = 4'd5,
    AluXor   = 4'd6,
    AluSll   = 4'd7,
    AluSrl   = 4'd8
  } aluOpE;

  // Core run control
  typedef enum logic {
    RunIdle = 1'b0,
    RunExec = 1'b1
  } runStateE;

endpackage

// File: common/decodeExecIf.sv
`timescale 1ns/1ps

interface decodeExecIf;

  dcupIsaPkg::wordT   instr;      // Instruction word, dropped opcodes as NOP
  dcupPipePkg::aluOpE aluOp;
  dcupIsaPkg::wordT   opA;
  dcupIsaPkg::wordT   opB;
  dcupIsaPkg::wordT   storeData;  // r1 value for STORE
  logic               setsFlag;   // Updates the zero flag

  // Decode side registers the fields
  modport dec (
    output instr,
    output aluOp,
    output opA,
    output opB,
    output storeData,
    output setsFlag
  );

  modport exe (
    input instr,
    input aluOp,
    input opA,
    input opB,
    input storeData,
    input setsFlag
  );

endinterface

// File: core/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 EN,
  input  logic                 Start,
  input  dcupIsaPkg::wordT     Inst,
  input  logic                 branchTaken,
  input  dcupIsaPkg::instAddrT branchTarget,
  input  logic                 haltSeen,
  output dcupIsaPkg::instAddrT pc,
  output dcupIsaPkg::wordT     fetchedInstr,
  output logic                 running
);

  dcupPipePkg::runStateE state;
  dcupPipePkg::runStateE nextState;

  ////////////////////////////////////////////////////////////
  // Run/idle control

  always_comb begin
    nextState = state;
    case (state)
      dcupPipePkg::RunIdle: begin
        if (EN && Start) begin
          nextState = dcupPipePkg::RunExec;
        end
      end
      dcupPipePkg::RunExec: begin
        // HALT in writeback or enable dropped
        if (!EN || haltSeen) begin
          nextState = dcupPipePkg::RunIdle;
        end
      end
      default: nextState = dcupPipePkg::RunIdle;
    endcase
  end

  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      state <= dcupPipePkg::RunIdle;
    end else begin
      state <= nextState;
    end
  end

  assign running = (state == dcupPipePkg::RunExec);

  ////////////////////////////////////////////////////////////
  // Program counter and fetch register

  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      pc           <= '0;
      fetchedInstr <= '0;
    end else if (running) begin
      fetchedInstr <= Inst;
      if (branchTaken) begin
        pc <= branchTarget;   // Redirect from memory stage
      end else begin
        pc <= pc + 1'b1;
      end
    end else if (EN && Start) begin
      pc <= '0;               // New run fetches from address 0
    end
  end

endmodule

// File: core/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
  input  logic               CLK,
  input  logic               RST,
  input  logic               running,
  input  dcupIsaPkg::wordT   fetchedInstr,
  input  dcupIsaPkg::wordT   rdData1,
  input  dcupIsaPkg::wordT   rdData2,
  input  dcupIsaPkg::wordT   rdData3,
  output dcupIsaPkg::regIdxT rdIdx1,
  output dcupIsaPkg::regIdxT rdIdx2,
  output dcupIsaPkg::regIdxT rdIdx3,
  decodeExecIf.dec           ex
);

  dcupIsaPkg::opcodeE opcode;
  dcupIsaPkg::wordT   imm8;
  dcupIsaPkg::wordT   offset4;

  dcupPipePkg::aluOpE nxtAluOp;
  dcupIsaPkg::wordT   nxtOpA;
  dcupIsaPkg::wordT   nxtOpB;
  dcupIsaPkg::wordT   nxtStoreData;
  logic               nxtSetsFlag;
  logic               keep;           // Opcode is implemented

  // Register reads straight from the fetch register
  assign rdIdx1 = dcupIsaPkg::r1Of(fetchedInstr);
  assign rdIdx2 = dcupIsaPkg::r2Of(fetchedInstr);
  assign rdIdx3 = dcupIsaPkg::r3Of(fetchedInstr);

  assign opcode  = dcupIsaPkg::opcodeOf(fetchedInstr);
  assign imm8    = dcupIsaPkg::wordT'(dcupIsaPkg::imm8Of(fetchedInstr));
  assign offset4 = dcupIsaPkg::wordT'(dcupIsaPkg::val3Of(fetchedInstr));

  ////////////////////////////////////////////////////////////
  // Operand and ALU operation select

  always_comb begin
    nxtAluOp     = dcupPipePkg::AluPassB;
    nxtOpA       = '0;
    nxtOpB       = '0;
    nxtStoreData = '0;
    nxtSetsFlag  = 1'b0;
    keep         = 1'b1;
    case (opcode)
      dcupIsaPkg::NOP, dcupIsaPkg::HALT: begin
        keep = 1'b1;
      end
      dcupIsaPkg::LOAD, dcupIsaPkg::STORE: begin
        nxtAluOp     = dcupPipePkg::AluAdd;   // r2 + val3
        nxtOpA       = rdData2;
        nxtOpB       = offset4;
        nxtStoreData = rdData1;
      end
      dcupIsaPkg::LDIL, dcupIsaPkg::JUMP: begin
        nxtOpB = imm8;
      end
      dcupIsaPkg::LDIH: begin
        nxtOpB = {dcupIsaPkg::imm8Of(fetchedInstr), 8'h00};
      end
      dcupIsaPkg::BZ, dcupIsaPkg::BNZ: begin
        nxtAluOp = dcupPipePkg::AluAdd;       // Target r1 + imm
        nxtOpA   = rdData1;
        nxtOpB   = imm8;
      end
      dcupIsaPkg::ADDI: begin
        nxtAluOp    = dcupPipePkg::AluAdd;
        nxtOpA      = rdData1;
        nxtOpB      = imm8;
        nxtSetsFlag = 1'b1;
      end
      dcupIsaPkg::ADD, dcupIsaPkg::SUB, dcupIsaPkg::CMP, dcupIsaPkg::AND,
      dcupIsaPkg::OR, dcupIsaPkg::XOR, dcupIsaPkg::SLL, dcupIsaPkg::SRL: begin
        nxtOpA      = rdData2;
        nxtOpB      = rdData3;
        nxtSetsFlag = 1'b1;
        case (opcode)
          dcupIsaPkg::ADD: nxtAluOp = dcupPipePkg::AluAdd;
          dcupIsaPkg::SUB: nxtAluOp = dcupPipePkg::AluSub;
          dcupIsaPkg::CMP: nxtAluOp = dcupPipePkg::AluCmp;
          dcupIsaPkg::AND: nxtAluOp = dcupPipePkg::AluAnd;
          dcupIsaPkg::OR:  nxtAluOp = dcupPipePkg::AluOr;
          dcupIsaPkg::XOR: nxtAluOp = dcupPipePkg::AluXor;
          dcupIsaPkg::SLL: nxtAluOp = dcupPipePkg::AluSll;
          default:         nxtAluOp = dcupPipePkg::AluSrl;
        endcase
      end
      default: begin
        keep = 1'b0;   // Carry, sign and other unsupported ops
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decode stage register

  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      ex.instr     <= '0;
      ex.aluOp     <= dcupPipePkg::AluPassB;
      ex.opA       <= '0;
      ex.opB       <= '0;
      ex.storeData <= '0;
      ex.setsFlag  <= 1'b0;
    end else if (running) begin
      ex.instr     <= keep ? fetchedInstr : '0;   // Unsupported opcode becomes NOP
      ex.aluOp     <= nxtAluOp;
      ex.opA       <= nxtOpA;
      ex.opB       <= nxtOpB;
      ex.storeData <= nxtStoreData;
      ex.setsFlag  <= nxtSetsFlag;
    end
  end

endmodule

// File: core/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic               CLK,
  input  logic               RST,
  input  logic               wbEn,
  input  dcupIsaPkg::regIdxT wbIdx,
  input  dcupIsaPkg::wordT   wbData,
  input  dcupIsaPkg::regIdxT rdIdx1,
  input  dcupIsaPkg::regIdxT rdIdx2,
  input  dcupIsaPkg::regIdxT rdIdx3,
  output dcupIsaPkg::wordT   rdData1,
  output dcupIsaPkg::wordT   rdData2,
  output dcupIsaPkg::wordT   rdData3
);

  dcupIsaPkg::wordT regs [dcupIsaPkg::NumRegs];

  // Single write port from writeback
  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      for (int i = 0; i < dcupIsaPkg::NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn) begin
      regs[wbIdx] <= wbData;
    end
  end

  // Reads see the old value in the write cycle
  assign rdData1 = regs[rdIdx1];
  assign rdData2 = regs[rdIdx2];
  assign rdData3 = regs[rdIdx3];

endmodule

// File: core/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 running,
  decodeExecIf.exe             ex,
  input  dcupIsaPkg::wordT     DataIn,
  output dcupIsaPkg::dataAddrT dataAddr,
  output logic                 dataWe,
  output dcupIsaPkg::wordT     dataOut,
  output logic                 branchTaken,
  output dcupIsaPkg::instAddrT branchTarget,
  output logic                 haltSeen,
  output logic                 wbEn,
  output dcupIsaPkg::regIdxT   wbIdx,
  output dcupIsaPkg::wordT     wbData
);

  dcupIsaPkg::wordT                aluResult;
  logic [dcupPipePkg::ShiftAmtW-1:0] shiftAmt;

  // Execute stage register
  dcupIsaPkg::wordT exeInstr;
  dcupIsaPkg::wordT exeResult;
  dcupIsaPkg::wordT exeStoreData;
  logic             exeWe;
  logic             zeroFlag;

  // Memory stage register
  dcupIsaPkg::wordT memInstr;
  dcupIsaPkg::wordT memData;
  logic             memWrites;

  ////////////////////////////////////////////////////////////
  // ALU

  assign shiftAmt = ex.opB[dcupPipePkg::ShiftAmtW-1:0];

  always_comb begin
    case (ex.aluOp)
      dcupPipePkg::AluPassB: aluResult = ex.opB;
      dcupPipePkg::AluAdd:   aluResult = ex.opA + ex.opB;
      dcupPipePkg::AluSub,
      dcupPipePkg::AluCmp:   aluResult = ex.opA - ex.opB;
      dcupPipePkg::AluAnd:   aluResult = ex.opA & ex.opB;
      dcupPipePkg::AluOr:    aluResult = ex.opA | ex.opB;
      dcupPipePkg::AluXor:   aluResult = ex.opA ^ ex.opB;
      dcupPipePkg::AluSll:   aluResult = ex.opA << shiftAmt;
      dcupPipePkg::AluSrl:   aluResult = ex.opA >> shiftAmt;
      default:               aluResult = '0;
    endcase
  end

  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      exeInstr     <= '0;
      exeResult    <= '0;
      exeStoreData <= '0;
      exeWe        <= 1'b0;
      zeroFlag     <= 1'b0;
    end else if (running) begin
      exeInstr     <= ex.instr;
      exeResult    <= aluResult;
      exeStoreData <= ex.storeData;
      exeWe        <= (dcupIsaPkg::opcodeOf(ex.instr) == dcupIsaPkg::STORE);
      if (ex.setsFlag) begin
        zeroFlag <= (aluResult == '0);   // Kept until the next flag writer
      end
    end else begin
      exeWe <= 1'b0;   // No memory writes once idle
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory stage

  assign dataAddr = exeResult[dcupIsaPkg::DataAddrW-1:0];
  assign dataWe   = exeWe;
  assign dataOut  = exeStoreData;

  // Branch decision goes back to fetch
  always_comb begin
    case (dcupIsaPkg::opcodeOf(exeInstr))
      dcupIsaPkg::JUMP: branchTaken = 1'b1;
      dcupIsaPkg::BZ:   branchTaken = zeroFlag;
      dcupIsaPkg::BNZ:  branchTaken = !zeroFlag;
      default:          branchTaken = 1'b0;
    endcase
  end

  assign branchTarget = exeResult[dcupIsaPkg::InstAddrW-1:0];

  always_ff @(posedge CLK, posedge RST) begin
    if (RST) begin
      memInstr <= '0;
      memData  <= '0;
    end else if (running) begin
      memInstr <= exeInstr;
      if (dcupIsaPkg::opcodeOf(exeInstr) == dcupIsaPkg::LOAD) begin
        memData <= DataIn;
      end else begin
        memData <= exeResult;
      end
    end else begin
      memInstr <= '0;   // Cleared while idle
      memData  <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Writeback

  always_comb begin
    case (dcupIsaPkg::opcodeOf(memInstr))
      dcupIsaPkg::LOAD, dcupIsaPkg::LDIL, dcupIsaPkg::LDIH,
      dcupIsaPkg::ADD, dcupIsaPkg::ADDI, dcupIsaPkg::SUB,
      dcupIsaPkg::AND, dcupIsaPkg::OR, dcupIsaPkg::XOR,
      dcupIsaPkg::SLL, dcupIsaPkg::SRL: memWrites = 1'b1;
      default:                          memWrites = 1'b0;   // CMP only sets the flag
    endcase
  end

  assign wbEn     = running && memWrites;
  assign wbIdx    = dcupIsaPkg::r1Of(memInstr);
  assign wbData   = memData;
  assign haltSeen = (dcupIsaPkg::opcodeOf(memInstr) == dcupIsaPkg::HALT);

endmodule

// File: hdl/dcupTop.sv
`timescale 1ns/1ps

module dcupTop (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 EN,
  input  logic                 Start,
  output dcupIsaPkg::instAddrT InstMemAddr,
  input  dcupIsaPkg::wordT     Inst,
  output dcupIsaPkg::dataAddrT DataMemAddr,
  input  dcupIsaPkg::wordT     DataIn,
  output logic                 DataMemWE,
  output dcupIsaPkg::wordT     DataOut,
  output logic                 Running
);

  dcupIsaPkg::wordT     fetchedInstr;
  logic                 branchTaken;
  dcupIsaPkg::instAddrT branchTarget;
  logic                 haltSeen;

  // Register file ports
  dcupIsaPkg::regIdxT   rdIdx1;
  dcupIsaPkg::regIdxT   rdIdx2;
  dcupIsaPkg::regIdxT   rdIdx3;
  dcupIsaPkg::wordT     rdData1;
  dcupIsaPkg::wordT     rdData2;
  dcupIsaPkg::wordT     rdData3;
  logic                 wbEn;
  dcupIsaPkg::regIdxT   wbIdx;
  dcupIsaPkg::wordT     wbData;

  decodeExecIf ex_i ();

  fetchUnit fetch_i (
    .CLK          (CLK),
    .RST          (RST),
    .EN           (EN),
    .Start        (Start),
    .Inst         (Inst),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .haltSeen     (haltSeen),
    .pc           (InstMemAddr),
    .fetchedInstr (fetchedInstr),
    .running      (Running)
  );

  decodeUnit decode_i (
    .CLK          (CLK),
    .RST          (RST),
    .running      (Running),
    .fetchedInstr (fetchedInstr),
    .rdData1      (rdData1),
    .rdData2      (rdData2),
    .rdData3      (rdData3),
    .rdIdx1       (rdIdx1),
    .rdIdx2       (rdIdx2),
    .rdIdx3       (rdIdx3),
    .ex           (ex_i.dec)
  );

  registerFile regFile_i (
    .CLK     (CLK),
    .RST     (RST),
    .wbEn    (wbEn),
    .wbIdx   (wbIdx),
    .wbData  (wbData),
    .rdIdx1  (rdIdx1),
    .rdIdx2  (rdIdx2),
    .rdIdx3  (rdIdx3),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .rdData3 (rdData3)
  );

  executeUnit execute_i (
    .CLK          (CLK),
    .RST          (RST),
    .running      (Running),
    .ex           (ex_i.exe),
    .DataIn       (DataIn),
    .dataAddr     (DataMemAddr),
    .dataWe       (DataMemWE),
    .dataOut      (DataOut),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .haltSeen     (haltSeen),
    .wbEn         (wbEn),
    .wbIdx        (wbIdx),
    .wbData       (wbData)
  );

endmodule

// File: dv/dcupTop_asserts.sv
`timescale 1ns/1ps

module dcupTop_asserts (
  input logic                 CLK,
  input logic                 RST,
  input logic                 EN,
  input logic                 Start,
  input logic                 Running,
  input logic                 DataMemWE,
  input dcupIsaPkg::instAddrT InstMemAddr
);

  // No writes once idle has settled
  assert property (@(posedge CLK) disable iff (RST)
    (!Running && $past(!Running)) |-> !DataMemWE)
    else $error("DataMemWE high while the core is idle");

  assert property (@(posedge CLK) disable iff (RST)
    (!Running && !(EN && Start)) |=> $stable(InstMemAddr))
    else $error("InstMemAddr moved while the core is idle");

  assert property (@(posedge CLK) RST |-> !Running)
    else $error("Running high during reset");

endmodule

bind dcupTop dcupTop_asserts asserts_i (.*);

// File: dv/dcupTbModel.svh
`ifndef DCUP_TB_MODEL_SVH
`define DCUP_TB_MODEL_SVH

////////////////////////////////////////////////////////////
// Instruction encoders

// Register form {opc, r1, 0, r2, 0, r3}
function automatic dcupIsaPkg::wordT encR(dcupIsaPkg::opcodeE op, dcupIsaPkg::regIdxT d,
                                          dcupIsaPkg::regIdxT s2, dcupIsaPkg::regIdxT s3);
  return {op, d, 1'b0, s2, 1'b0, s3};
endfunction

function automatic dcupIsaPkg::wordT encI(dcupIsaPkg::opcodeE op, dcupIsaPkg::regIdxT d,
                                          logic [7:0] imm);
  return {op, d, imm};
endfunction

// LOAD and STORE with r2 base and 4-bit offset
function automatic dcupIsaPkg::wordT encM(dcupIsaPkg::opcodeE op, dcupIsaPkg::regIdxT d,
                                          dcupIsaPkg::regIdxT s2, logic [3:0] off);
  return {op, d, 1'b0, s2, off};
endfunction

////////////////////////////////////////////////////////////
// Instruction level model with three delay slots

function automatic void refModel();
  dcupIsaPkg::instAddrT pc;
  dcupIsaPkg::instAddrT pendTarget;
  dcupIsaPkg::instAddrT target;
  dcupIsaPkg::opcodeE   op;
  dcupIsaPkg::wordT     instr;
  dcupIsaPkg::wordT     a;
  dcupIsaPkg::wordT     b;
  dcupIsaPkg::wordT     res;
  dcupIsaPkg::wordT     sum;
  dcupIsaPkg::regIdxT   d;
  dcupIsaPkg::dataAddrT addr;
  logic [7:0]           imm;
  logic                 taken;
  logic                 setsFlag;
  logic                 writes;
  int                   pendCount;
  expStores.delete();
  pc        = '0;
  pendCount = 0;
  pendTarget = '0;
  for (int step = 0; step < 4096; step++) begin
    instr    = progMem[pc];
    op       = dcupIsaPkg::opcodeE'(instr[15:11]);
    d        = instr[10:8];
    imm      = instr[7:0];
    a        = refRegs[instr[6:4]];
    b        = refRegs[instr[2:0]];
    sum      = a + {12'h000, instr[3:0]};
    addr     = sum[7:0];
    res      = '0;
    target   = '0;
    taken    = 1'b0;
    setsFlag = 1'b1;
    writes   = 1'b1;
    if (op == dcupIsaPkg::HALT) begin
      break;
    end
    case (op)
      dcupIsaPkg::ADD:  res = a + b;
      dcupIsaPkg::ADDI: res = refRegs[d] + {8'h00, imm};
      dcupIsaPkg::SUB:  res = a - b;
      dcupIsaPkg::CMP:  res = a - b;
      dcupIsaPkg::AND:  res = a & b;
      dcupIsaPkg::OR:   res = a | b;
      dcupIsaPkg::XOR:  res = a ^ b;
      dcupIsaPkg::SLL:  res = a << b[3:0];
      dcupIsaPkg::SRL:  res = a >> b[3:0];
      default: begin
        setsFlag = 1'b0;
        writes   = 1'b0;
        case (op)
          dcupIsaPkg::LDIL: begin
            res    = {8'h00, imm};
            writes = 1'b1;
          end
          dcupIsaPkg::LDIH: begin
            res    = {imm, 8'h00};
            writes = 1'b1;
          end
          dcupIsaPkg::LOAD: begin
            res    = refMem[addr];
            writes = 1'b1;
          end
          dcupIsaPkg::STORE: begin
            refMem[addr] = refRegs[d];
            expStores.push_back({addr, refRegs[d]});
          end
          dcupIsaPkg::JUMP: begin
            taken  = 1'b1;
            target = imm;
          end
          dcupIsaPkg::BZ: begin
            taken  = refFlag;
            target = refRegs[d][7:0] + imm;
          end
          dcupIsaPkg::BNZ: begin
            taken  = !refFlag;
            target = refRegs[d][7:0] + imm;
          end
          default: ;   // Dropped opcodes act as NOP
        endcase
      end
    endcase
    if (op == dcupIsaPkg::CMP) begin
      writes = 1'b0;
    end
    if (setsFlag) begin
      refFlag = (res == '0);
    end
    if (writes) begin
      refRegs[d] = res;
    end
    if (pendCount > 0) begin
      pendCount--;
      pc = (pendCount == 0) ? pendTarget : pc + 1'b1;
    end else begin
      pc = pc + 1'b1;
    end
    if (taken) begin
      pendCount  = 3;   // Slots still running before redirect
      pendTarget = target;
    end
  end
endfunction

`endif

// File: dv/dcupTb.sv
`timescale 1ns/1ps

module dcupTb;

  logic                 CLK;
  logic                 RST;
  logic                 EN;
  logic                 Start;
  dcupIsaPkg::wordT     Inst;
  dcupIsaPkg::wordT     DataIn;
  dcupIsaPkg::instAddrT InstMemAddr;
  dcupIsaPkg::dataAddrT DataMemAddr;
  logic                 DataMemWE;
  dcupIsaPkg::wordT     DataOut;
  logic                 Running;

  dcupIsaPkg::wordT progMem [256];
  dcupIsaPkg::wordT dataMem [256];
  dcupIsaPkg::wordT refMem [256];
  dcupIsaPkg::wordT refRegs [8];
  logic             refFlag;
  logic [23:0]      expStores [$];   // {addr, data}
  logic [23:0]      gotStores [$];
  int               progLen;
  int               seed;
  int               testsRun;
  int               testsFailed;
  int               budget;
  int               cycles;

  // Store capture between edges
  logic                 latchWe;
  dcupIsaPkg::dataAddrT latchAddr;
  dcupIsaPkg::wordT     latchData;

  dcupIsaPkg::opcodeE aluOps [7] = '{dcupIsaPkg::ADD, dcupIsaPkg::SUB, dcupIsaPkg::AND,
                                     dcupIsaPkg::OR, dcupIsaPkg::XOR, dcupIsaPkg::SLL,
                                     dcupIsaPkg::SRL};

  `include "dcupTbModel.svh"

  dcupTop dut_i (
    .CLK         (CLK),
    .RST         (RST),
    .EN          (EN),
    .Start       (Start),
    .InstMemAddr (InstMemAddr),
    .Inst        (Inst),
    .DataMemAddr (DataMemAddr),
    .DataIn      (DataIn),
    .DataMemWE   (DataMemWE),
    .DataOut     (DataOut),
    .Running     (Running)
  );

  assign Inst   = progMem[InstMemAddr];   // Combinational memories
  assign DataIn = dataMem[DataMemAddr];

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(negedge CLK) begin
    latchWe   = DataMemWE;
    latchAddr = DataMemAddr;
    latchData = DataOut;
  end

  always @(posedge CLK) begin
    if (latchWe) begin
      dataMem[latchAddr] = latchData;
      gotStores.push_back({latchAddr, latchData});
    end
  end

  ////////////////////////////////////////////////////////////
  // Program building

  task automatic newProgram();
    for (int i = 0; i < 256; i++) begin
      progMem[i] = '0;
    end
    progLen = 0;
  endtask

  task automatic put(dcupIsaPkg::wordT w);
    progMem[progLen] = w;
    progLen++;
  endtask

  task automatic putSpaced(dcupIsaPkg::wordT w);
    put(w);
    repeat (3) put('0);   // Keeps every reader four slots behind
  endtask

  task automatic padTo(int addr);
    while (progLen < addr) put('0);
  endtask

  task automatic endProgram();
    put(encR(dcupIsaPkg::HALT, 0, 0, 0));
    repeat (5) put('0);   // Stale pipeline holds only NOPs
  endtask

  task automatic loadWord(dcupIsaPkg::regIdxT r, dcupIsaPkg::regIdxT tmp,
                          dcupIsaPkg::wordT v);
    putSpaced(encI(dcupIsaPkg::LDIL, r, v[7:0]));
    putSpaced(encI(dcupIsaPkg::LDIH, tmp, v[15:8]));
    putSpaced(encR(dcupIsaPkg::OR, r, r, tmp));
  endtask

  function automatic logic [7:0] rnd8();
    return 8'($random(seed));
  endfunction

  ////////////////////////////////////////////////////////////
  // Run and compare

  task automatic runProgram();
    for (int i = 0; i < 256; i++) begin
      refMem[i] = dataMem[i];
    end
    refModel();
    gotStores.delete();
    budget += progLen * 110;
    @(negedge CLK);
    Start = 1'b1;
    @(negedge CLK);
    Start = 1'b0;
    while (!Running) @(negedge CLK);
    while (Running) @(negedge CLK);
    @(negedge CLK);
  endtask

  task automatic compareRun(string name, output int fails);
    fails = 0;
    if (gotStores.size() != expStores.size()) begin
      $display("Fail %s: store count expected %0d, actual %0d", name,
               expStores.size(), gotStores.size());
      fails++;
    end
    for (int i = 0; i < gotStores.size() && i < expStores.size(); i++) begin
      if (gotStores[i] != expStores[i]) begin
        $display("Fail %s: store %0d expected %h, actual %h", name, i,
                 expStores[i], gotStores[i]);
        fails++;
      end
    end
    for (int a = 0; a < 256; a++) begin
      if (dataMem[a] !== refMem[a]) begin
        $display("Fail %s: mem[%0d] expected %h, actual %h", name, a, refMem[a], dataMem[a]);
        fails++;
      end
    end
  endtask

  task automatic finishTest(string name, int fails);
    testsRun++;
    if (fails == 0) begin
      $display("pass: %s", name);
    end else begin
      testsFailed++;
      $display("Test %s ended with %0d errors", name, fails);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  initial begin
    int fails;
    int more;
    logic [7:0] base;
    dcupIsaPkg::instAddrT hold;
    seed = 32'hc700_756c;
    testsRun = 0;
    testsFailed = 0;
    budget = 64;   // Reset plus slack
    RST = 1'b1;
    EN = 1'b0;
    Start = 1'b0;
    latchWe = 1'b0;
    refFlag = 1'b0;
    for (int i = 0; i < 8; i++) refRegs[i] = '0;
    for (int i = 0; i < 256; i++) dataMem[i] = '0;
    newProgram();
    repeat (16) @(negedge CLK);
    RST = 1'b0;
    EN = 1'b1;
    @(negedge CLK);

    fails = 0;
    if (Running !== 1'b0) begin
      $display("Fail reset: Running expected %b, actual %b", 1'b0, Running);
      fails++;
    end
    if (DataMemWE !== 1'b0) begin
      $display("Fail reset: DataMemWE expected %b, actual %b", 1'b0, DataMemWE);
      fails++;
    end
    if (InstMemAddr !== '0) begin
      $display("Fail reset: InstMemAddr expected %h, actual %h", 8'h00, InstMemAddr);
      fails++;
    end
    finishTest("reset", fails);

    newProgram();
    base = rnd8();
    putSpaced(encI(dcupIsaPkg::LDIL, 1, rnd8()));
    putSpaced(encI(dcupIsaPkg::LDIH, 2, rnd8()));
    putSpaced(encI(dcupIsaPkg::LDIL, 4, base));
    putSpaced(encR(dcupIsaPkg::OR, 3, 2, 1));
    put(encM(dcupIsaPkg::STORE, 1, 4, 0));
    put(encM(dcupIsaPkg::STORE, 2, 4, 1));
    putSpaced(encM(dcupIsaPkg::STORE, 3, 4, 2));
    endProgram();
    runProgram();
    compareRun("immediates", fails);
    finishTest("immediates", fails);

    newProgram();
    loadWord(1, 2, 16'($random(seed)));
    loadWord(3, 4, 16'($random(seed)));
    putSpaced(encI(dcupIsaPkg::LDIL, 7, rnd8()));
    for (int i = 0; i < 7; i++) begin
      putSpaced(encR(aluOps[i], 5, 1, 3));
      putSpaced(encM(dcupIsaPkg::STORE, 5, 7, 4'(i)));
    end
    putSpaced(encR(dcupIsaPkg::OR, 6, 1, 1));
    putSpaced(encI(dcupIsaPkg::ADDI, 6, rnd8()));
    putSpaced(encM(dcupIsaPkg::STORE, 6, 7, 7));
    endProgram();
    runProgram();
    compareRun("alu", fails);
    finishTest("alu", fails);

    newProgram();
    base = rnd8();
    dataMem[base] = 16'($random(seed));   // Preloaded operand
    loadWord(5, 6, 16'($random(seed)));
    putSpaced(encI(dcupIsaPkg::LDIL, 1, base));
    putSpaced(encM(dcupIsaPkg::LOAD, 2, 1, 0));
    putSpaced(encR(dcupIsaPkg::ADD, 4, 2, 5));
    putSpaced(encM(dcupIsaPkg::STORE, 2, 1, 1));
    putSpaced(encM(dcupIsaPkg::STORE, 4, 1, 3));
    endProgram();
    runProgram();
    compareRun("memory", fails);
    finishTest("memory", fails);

    // Marker offsets tell which path and delay slots ran
    newProgram();
    base = rnd8();
    putSpaced(encI(dcupIsaPkg::LDIL, 1, base));
    putSpaced(encI(dcupIsaPkg::LDIL, 2, base));
    putSpaced(encI(dcupIsaPkg::LDIL, 3, base ^ 8'h01));
    putSpaced(encI(dcupIsaPkg::LDIL, 5, 8'h00));
    putSpaced(encI(dcupIsaPkg::LDIL, 6, rnd8()));
    putSpaced(encI(dcupIsaPkg::LDIL, 7, 8'h5a));
    put(encR(dcupIsaPkg::CMP, 0, 1, 2));            // Flag set
    padTo(28);
    put(encI(dcupIsaPkg::BZ, 5, 8'd40));            // Taken
    for (int k = 0; k < 4; k++) put(encM(dcupIsaPkg::STORE, 7, 6, 4'(k)));
    padTo(40);
    put(encI(dcupIsaPkg::BNZ, 5, 8'd50));           // Not taken
    padTo(44);
    put(encM(dcupIsaPkg::STORE, 7, 6, 4));
    put(encR(dcupIsaPkg::CMP, 0, 1, 3));            // Flag clear
    padTo(49);
    put(encI(dcupIsaPkg::BNZ, 5, 8'd60));           // Taken
    padTo(53);
    put(encM(dcupIsaPkg::STORE, 7, 6, 5));
    padTo(60);
    put(encI(dcupIsaPkg::BZ, 5, 8'd70));            // Not taken
    padTo(64);
    put(encM(dcupIsaPkg::STORE, 7, 6, 6));
    put(encI(dcupIsaPkg::JUMP, 0, 8'd80));
    put(encM(dcupIsaPkg::STORE, 7, 6, 7));
    padTo(69);
    put(encM(dcupIsaPkg::STORE, 7, 6, 8));
    padTo(80);
    put(encM(dcupIsaPkg::STORE, 7, 6, 9));
    endProgram();
    runProgram();
    compareRun("control", fails);
    finishTest("control", fails);

    newProgram();
    putSpaced(encI(dcupIsaPkg::LDIL, 1, rnd8()));
    putSpaced(encI(dcupIsaPkg::LDIL, 2, rnd8()));
    put(encM(dcupIsaPkg::STORE, 1, 2, 0));
    endProgram();
    runProgram();
    compareRun("halt_restart", fails);
    hold = InstMemAddr;
    repeat (5) @(negedge CLK);
    if (Running !== 1'b0) begin
      $display("Fail halt_restart: Running expected %b, actual %b", 1'b0, Running);
      fails++;
    end
    if (InstMemAddr !== hold) begin
      $display("Fail halt_restart: InstMemAddr expected %h, actual %h", hold, InstMemAddr);
      fails++;
    end
    newProgram();
    putSpaced(encI(dcupIsaPkg::LDIL, 3, rnd8()));
    putSpaced(encM(dcupIsaPkg::STORE, 3, 2, 4));
    endProgram();
    runProgram();
    compareRun("halt_restart", more);
    finishTest("halt_restart", fails + more);

    $display("%0d tests run, %0d passed, %0d failed", testsRun, testsRun - testsFailed,
             testsFailed);
    if (testsFailed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog budget grows with each loaded program
  initial begin
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: the core did not finish its program in time");
    $display("tests failed");
    $finish;
  end

endmodule

// File: dcupTop.f
+incdir+dv
common/dcupIsaPkg.sv
common/dcupPipePkg.sv
common/decodeExecIf.sv
core/fetchUnit.sv
core/decodeUnit.sv
core/registerFile.sv
core/executeUnit.sv
hdl/dcupTop.sv
dv/dcupTop_asserts.sv
dv/dcupTb.sv

// File: Bender.yml
package:
  name: dcup

sources:
  - common/dcupIsaPkg.sv
  - common/dcupPipePkg.sv
  - common/decodeExecIf.sv
  - core/fetchUnit.sv
  - core/decodeUnit.sv
  - core/registerFile.sv
  - core/executeUnit.sv
  - hdl/dcupTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/dcupTop_asserts.sv
      - dv/dcupTb.sv
